/* Makefile */
TOP := rename_core_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f src.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | awk '{ print } /test passed/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

/* hw/arch_map.sv */
// committed areg to preg map updated at retirement, with a combinational query port
`timescale 1ns/100ps
`include "core_macros.svh"

module arch_map import rename_pkg::*; (
	input  logic      clk,
	input  logic      reset_i,
	retire_if.sink    ret,
	input  areg_idx_t arch_areg_i,		// query
	output preg_idx_t arch_preg_o
);

	preg_idx_t commit_tbl [`CORE_AREG_NUM];	// in-order view of the map

	always_ff @(posedge clk) begin
		if (reset_i) begin
			for (int i = 0; i < `CORE_AREG_NUM; i++) begin
				commit_tbl[i] <= preg_idx_t'(i);	// same identity as the speculative map
			end
		end else if (ret.retire_en && ret.has_dest) begin
			commit_tbl[ret.dest_areg] <= ret.new_preg;
		end
	end

	// shows the state before this edge's retirement
	assign arch_preg_o = commit_tbl[arch_areg_i];

endmodule

/* hw/core_ifs.sv */
// allocation and retirement bundles used between the rename stage, the ROB and the sinks
`timescale 1ns/100ps

//==========================================================================
// dispatch into the ROB
//==========================================================================
interface rob_alloc_if import rename_pkg::*, rob_pkg::*; ();
	logic      alloc_en;	// entry written at this edge
	logic      has_dest;
	areg_idx_t dest_areg;
	preg_idx_t new_preg;
	preg_idx_t old_preg;
	logic      full;		// no free slot this cycle
	rob_idx_t  alloc_idx;	// tail slot, valid with alloc_en

	// rename side, never raises alloc_en while full
	modport rename (
		output alloc_en, has_dest, dest_areg, new_preg, old_preg,
		input  full, alloc_idx
	);

	modport rob (
		input  alloc_en, has_dest, dest_areg, new_preg, old_preg,
		output full, alloc_idx
	);
endinterface

//==========================================================================
// in-order retirement broadcast
//==========================================================================
interface retire_if import rename_pkg::*; ();
	logic      retire_en;	// one head entry per cycle, no stall
	logic      has_dest;
	areg_idx_t dest_areg;
	preg_idx_t new_preg;	// becomes committed
	preg_idx_t old_preg;	// goes back to the free list

	modport rob (output retire_en, has_dest, dest_areg, new_preg, old_preg);

	// free list and committed map act at the same edge
	modport sink (input retire_en, has_dest, dest_areg, new_preg, old_preg);
endinterface

/* hw/core_macros.svh */
// register counts and ROB depth of the rename core, included by the packages and the sized RTL
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

//==========================================================================
// register file sizes
//==========================================================================
`define CORE_AREG_NUM		32		// architectural registers
`define CORE_PREG_NUM		64		// physical registers

// areg with a fixed mapping, never renamed and never freed
`define CORE_ZERO_REG		31

//==========================================================================
// retirement window
//==========================================================================
`define CORE_ROB_DEPTH		16		// in-flight instructions

`endif

/* hw/free_list.sv */
// queue of unmapped physical registers, filled after reset and refilled by retirement
`timescale 1ns/100ps
`include "core_macros.svh"

module free_list import rename_pkg::*; (
	input  logic      clk,
	input  logic      reset_i,
	input  logic      alloc_i,			// take head_o at this edge
	output preg_idx_t free_preg_o,		// next tag to hand out
	output logic      empty_o,
	retire_if.sink    ret
);

	// pregs above the identity map start out free
	localparam int        FREE_NUM   = `CORE_PREG_NUM - `CORE_AREG_NUM;
	localparam preg_idx_t FILL_FIRST = preg_idx_t'(`CORE_AREG_NUM);
	localparam preg_idx_t FILL_LAST  = preg_idx_t'(`CORE_PREG_NUM - 1);

	logic      fill_active;		// post-reset fill still running
	preg_idx_t fill_preg;		// tag pushed this cycle during fill
	logic      q_push;
	preg_idx_t q_push_preg;
	logic      q_empty;

	// one tag per cycle, upward from the first unmapped preg
	always_ff @(posedge clk) begin
		if (reset_i) begin
			fill_active <= 1'b1;
			fill_preg   <= FILL_FIRST;
		end else if (fill_active) begin
			if (fill_preg == FILL_LAST) fill_active <= 1'b0;
			else fill_preg <= fill_preg + 1'b1;
		end
	end

	// no renamed dest can retire while filling, so the two sources never collide
	assign q_push      = fill_active | (ret.retire_en & ret.has_dest);
	assign q_push_preg = fill_active ? fill_preg : ret.old_preg;
	assign empty_o     = fill_active | q_empty;	// hold off allocation until the fill ends

	ring_fifo #(
		.DEPTH	(FREE_NUM),
		.T		(preg_idx_t)
	) u_queue (
		.clk			(clk),
		.reset_i		(reset_i),
		.push_i			(q_push),
		.push_data_i	(q_push_preg),
		.pop_i			(alloc_i),
		.head_o			(free_preg_o),
		.empty_o		(q_empty),
		.full_o			(),
		.wr_ptr_o		(),
		.rd_ptr_o		()
	);

endmodule

/* hw/rename_core.sv */
// top of the rename and retirement backbone, decoded instructions in and retirements out
`timescale 1ns/100ps

module rename_core import rename_pkg::*, rob_pkg::*; (
	input  logic      clk,
	input  logic      reset_i,

	// dispatch, taken when valid and ready are both high
	input  logic      dispatch_valid_i,
	input  areg_idx_t dest_areg_i,
	input  areg_idx_t src_a_areg_i,
	input  areg_idx_t src_b_areg_i,
	output logic      dispatch_ready_o,
	output preg_idx_t dest_preg_o,
	output preg_idx_t src_a_preg_o,
	output logic      src_a_rdy_o,
	output preg_idx_t src_b_preg_o,
	output logic      src_b_rdy_o,
	output rob_idx_t  rob_idx_o,			// completion tag for this instruction

	// completion, reported by ROB index
	input  logic      complete_valid_i,
	input  rob_idx_t  complete_idx_i,

	// retirement
	output logic      retire_valid_o,
	output areg_idx_t retire_areg_o,
	output preg_idx_t retire_preg_o,

	// committed map query
	input  areg_idx_t arch_areg_i,
	output preg_idx_t arch_preg_o
);

	logic      wakeup_en;
	preg_idx_t wakeup_preg;

	rob_alloc_if u_alloc_if ();
	retire_if    u_retire_if ();

	assign rob_idx_o      = u_alloc_if.alloc_idx;
	assign retire_valid_o = u_retire_if.retire_en;
	assign retire_areg_o  = u_retire_if.dest_areg;
	assign retire_preg_o  = u_retire_if.new_preg;

	rename_stage u_rename_stage (
		.clk				(clk),
		.reset_i			(reset_i),
		.dispatch_valid_i	(dispatch_valid_i),
		.dest_areg_i		(dest_areg_i),
		.src_a_areg_i		(src_a_areg_i),
		.src_b_areg_i		(src_b_areg_i),
		.dispatch_ready_o	(dispatch_ready_o),
		.dest_preg_o		(dest_preg_o),
		.src_a_preg_o		(src_a_preg_o),
		.src_a_rdy_o		(src_a_rdy_o),
		.src_b_preg_o		(src_b_preg_o),
		.src_b_rdy_o		(src_b_rdy_o),
		.alloc				(u_alloc_if),
		.ret				(u_retire_if),
		.wakeup_en_i		(wakeup_en),
		.wakeup_preg_i		(wakeup_preg)
	);

	rob u_rob (
		.clk				(clk),
		.reset_i			(reset_i),
		.alloc				(u_alloc_if),
		.complete_valid_i	(complete_valid_i),
		.complete_idx_i		(complete_idx_i),
		.wakeup_en_o		(wakeup_en),
		.wakeup_preg_o		(wakeup_preg),
		.ret				(u_retire_if)
	);

	arch_map u_arch_map (
		.clk			(clk),
		.reset_i		(reset_i),
		.ret			(u_retire_if),
		.arch_areg_i	(arch_areg_i),
		.arch_preg_o	(arch_preg_o)
	);

endmodule

/* hw/rename_pkg.sv */
// register naming types shared by the map tables, the free list and the ports
`include "core_macros.svh"

package rename_pkg;

	// index widths follow the counts in the macro header
	localparam int AREG_W = $clog2(`CORE_AREG_NUM);
	localparam int PREG_W = $clog2(`CORE_PREG_NUM);

	// architectural register number, as decoded
	typedef logic [AREG_W-1:0] areg_idx_t;

	// physical register tag
	typedef logic [PREG_W-1:0] preg_idx_t;

endpackage

/* hw/rename_stage.sv */
// dispatch gate with the speculative map table and per-preg ready bits, feeds the ROB
`timescale 1ns/100ps
`include "core_macros.svh"

module rename_stage import rename_pkg::*; (
	input  logic        clk,
	input  logic        reset_i,
	input  logic        dispatch_valid_i,
	input  areg_idx_t   dest_areg_i,
	input  areg_idx_t   src_a_areg_i,
	input  areg_idx_t   src_b_areg_i,
	output logic        dispatch_ready_o,
	output preg_idx_t   dest_preg_o,
	output preg_idx_t   src_a_preg_o,
	output logic        src_a_rdy_o,
	output preg_idx_t   src_b_preg_o,
	output logic        src_b_rdy_o,
	rob_alloc_if.rename alloc,
	retire_if.sink      ret,
	input  logic        wakeup_en_i,		// completion broadcast from the ROB
	input  preg_idx_t   wakeup_preg_i
);

	localparam areg_idx_t ZERO_AREG = areg_idx_t'(`CORE_ZERO_REG);

	preg_idx_t                 map_tbl [`CORE_AREG_NUM];	// speculative areg to preg
	logic [`CORE_PREG_NUM-1:0] rdy_bits;					// value produced
	logic                      dest_is_zero;
	logic                      dispatch_fire;
	logic                      fl_alloc;
	logic                      fl_empty;
	preg_idx_t                 fl_free_preg;

	//==========================================================================
	// stall rule
	//==========================================================================
	assign dest_is_zero     = (dest_areg_i == ZERO_AREG);	// zero reg needs no free tag
	assign dispatch_ready_o = (~fl_empty | dest_is_zero) & ~alloc.full;
	assign dispatch_fire    = dispatch_valid_i & dispatch_ready_o;
	assign fl_alloc         = dispatch_fire & ~dest_is_zero;

	// sources read the map before this edge's update, no same-cycle forwarding
	assign src_a_preg_o = map_tbl[src_a_areg_i];
	assign src_a_rdy_o  = rdy_bits[src_a_preg_o];
	assign src_b_preg_o = map_tbl[src_b_areg_i];
	assign src_b_rdy_o  = rdy_bits[src_b_preg_o];
	assign dest_preg_o  = dest_is_zero ? map_tbl[ZERO_AREG] : fl_free_preg;

	// ROB entry
	assign alloc.alloc_en  = dispatch_fire;
	assign alloc.has_dest  = ~dest_is_zero;
	assign alloc.dest_areg = dest_areg_i;
	assign alloc.new_preg  = dest_preg_o;
	assign alloc.old_preg  = map_tbl[dest_areg_i];	// freed when this entry retires

	//==========================================================================
	// map and ready state
	//==========================================================================
	always_ff @(posedge clk) begin
		if (reset_i) begin
			for (int i = 0; i < `CORE_AREG_NUM; i++) begin
				map_tbl[i] <= preg_idx_t'(i);		// identity
			end
		end else if (fl_alloc) begin
			map_tbl[dest_areg_i] <= fl_free_preg;
		end
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			rdy_bits <= '1;		// committed values all present
		end else begin
			if (wakeup_en_i) rdy_bits[wakeup_preg_i] <= 1'b1;
			if (fl_alloc) rdy_bits[fl_free_preg] <= 1'b0;	// new tag pending
		end
	end

	free_list u_free_list (
		.clk			(clk),
		.reset_i		(reset_i),
		.alloc_i		(fl_alloc),
		.free_preg_o	(fl_free_preg),
		.empty_o		(fl_empty),
		.ret			(ret)
	);

endmodule

/* hw/ring_fifo.sv */
// circular queue for any payload type, pointers exposed so a user can index slots directly
`timescale 1ns/100ps

module ring_fifo #(
	parameter int  DEPTH = 16,
	parameter type T     = logic [7:0]
) (
	input  logic                     clk,
	input  logic                     reset_i,
	input  logic                     push_i,
	input  T                         push_data_i,
	input  logic                     pop_i,
	output T                         head_o,		// oldest entry, combinational
	output logic                     empty_o,
	output logic                     full_o,
	output logic [$clog2(DEPTH)-1:0] wr_ptr_o,		// slot the next push lands in
	output logic [$clog2(DEPTH)-1:0] rd_ptr_o		// slot of head_o
);

	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);
	localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);
	localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(DEPTH);

	T                 mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;		// occupancy, tells full from empty
	logic             do_push;
	logic             do_pop;

	// wrap for depths that are not a power of two
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		return (ptr == LAST_PTR) ? '0 : ptr + 1'b1;
	endfunction

	assign do_push = push_i & ~full_o;		// push into a full queue is dropped
	assign do_pop  = pop_i & ~empty_o;

	always_ff @(posedge clk) begin
		if (reset_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) wr_ptr <= next_ptr(wr_ptr);
			if (do_pop) rd_ptr <= next_ptr(rd_ptr);
			if (do_push && !do_pop) count <= count + 1'b1;
			else if (do_pop && !do_push) count <= count - 1'b1;	// both at once keeps count
		end
	end

	// storage
	always_ff @(posedge clk) begin
		if (do_push) mem[wr_ptr] <= push_data_i;
	end

	assign head_o   = mem[rd_ptr];
	assign empty_o  = (count == '0);
	assign full_o   = (count == FULL_CNT);
	assign wr_ptr_o = wr_ptr;
	assign rd_ptr_o = rd_ptr;

endmodule

/* hw/rob.sv */
// reorder buffer, marks entries done by index and retires the head in program order
`timescale 1ns/100ps
`include "core_macros.svh"

module rob import rename_pkg::*, rob_pkg::*; (
	input  logic      clk,
	input  logic      reset_i,
	rob_alloc_if.rob  alloc,
	input  logic      complete_valid_i,	// instruction at complete_idx_i finished
	input  rob_idx_t  complete_idx_i,
	output logic      wakeup_en_o,
	output preg_idx_t wakeup_preg_o,
	retire_if.rob     ret
);

	rob_entry_t                 alloc_entry;
	rob_entry_t                 head_entry;
	rob_idx_t                   head_idx;
	logic                       q_empty;
	logic [`CORE_ROB_DEPTH-1:0] done_bits;		// per slot, set by completion
	logic [`CORE_ROB_DEPTH-1:0] wake_dest;		// slot renames a register
	preg_idx_t                  wake_preg [`CORE_ROB_DEPTH];	// slot's new tag

	assign alloc_entry = '{
		has_dest:  alloc.has_dest,
		dest_areg: alloc.dest_areg,
		new_preg:  alloc.new_preg,
		old_preg:  alloc.old_preg
	};

	// tail pointer doubles as the allocated index
	ring_fifo #(
		.DEPTH	(`CORE_ROB_DEPTH),
		.T		(rob_entry_t)
	) u_entries (
		.clk			(clk),
		.reset_i		(reset_i),
		.push_i			(alloc.alloc_en),
		.push_data_i	(alloc_entry),
		.pop_i			(ret.retire_en),
		.head_o			(head_entry),
		.empty_o		(q_empty),
		.full_o			(alloc.full),
		.wr_ptr_o		(alloc.alloc_idx),
		.rd_ptr_o		(head_idx)
	);

	//==========================================================================
	// completion tracking
	//==========================================================================
	always_ff @(posedge clk) begin
		if (reset_i) begin
			done_bits <= '0;
		end else begin
			if (alloc.alloc_en) done_bits[alloc.alloc_idx] <= 1'b0;	// fresh slot
			if (complete_valid_i) done_bits[complete_idx_i] <= 1'b1;
		end
	end

	// side copy of the tag so a completion can look it up by index
	always_ff @(posedge clk) begin
		if (alloc.alloc_en) begin
			wake_dest[alloc.alloc_idx] <= alloc.has_dest;
			wake_preg[alloc.alloc_idx] <= alloc.new_preg;
		end
	end

	// rename sets the ready bit at the completion edge
	assign wakeup_en_o   = complete_valid_i & wake_dest[complete_idx_i];
	assign wakeup_preg_o = wake_preg[complete_idx_i];

	//==========================================================================
	// retire
	//==========================================================================
	// done bit is a flop, so retire trails completion by a cycle at least
	assign ret.retire_en = ~q_empty & done_bits[head_idx];
	assign ret.has_dest  = head_entry.has_dest;
	assign ret.dest_areg = head_entry.dest_areg;
	assign ret.new_preg  = head_entry.new_preg;
	assign ret.old_preg  = head_entry.old_preg;

endmodule

/* hw/rob_pkg.sv */
// reorder buffer index and entry layout, imported by the ROB, its interfaces and the top
`include "core_macros.svh"

package rob_pkg;
	import rename_pkg::*;

	localparam int ROB_W = $clog2(`CORE_ROB_DEPTH);

	// slot number, also the completion tag
	typedef logic [ROB_W-1:0] rob_idx_t;

	// one in-flight instruction
	typedef struct packed {
		logic      has_dest;	// writes a renamed register
		areg_idx_t dest_areg;	// committed map slot on retire
		preg_idx_t new_preg;	// tag given at dispatch
		preg_idx_t old_preg;	// previous mapping, freed on retire
	} rob_entry_t;

endpackage

/* src.f */
+incdir+hw
hw/rename_pkg.sv
hw/rob_pkg.sv
hw/core_ifs.sv
hw/ring_fifo.sv
hw/free_list.sv
hw/rename_stage.sv
hw/rob.sv
hw/arch_map.sv
hw/rename_core.sv
verification/rename_core_tb.sv

/* verification/rename_core_tb.sv */
// testbench that drives the rename core and checks every output against a reference model
`timescale 1ns/100ps
`include "core_macros.svh"

module rename_core_tb import rename_pkg::*, rob_pkg::*; ();

	localparam areg_idx_t ZERO_AREG    = areg_idx_t'(`CORE_ZERO_REG);
	localparam int        RESET_CYCLES = 2;
	localparam int        RAND_CYCLES  = 600;		// mixed traffic length
	localparam int        STALL_HOLD   = 8;		// cycles held against a full ROB
	localparam int        DRAIN_LIMIT  = 4 * `CORE_ROB_DEPTH;
	localparam int        WATCHDOG_CYCLES = 2 * (RESET_CYCLES + `CORE_AREG_NUM + RAND_CYCLES
		+ 2 * DRAIN_LIMIT + 2 * `CORE_ROB_DEPTH + STALL_HOLD);

	// model copy of one in-flight instruction
	typedef struct packed {
		rob_idx_t  idx;
		logic      has_dest;
		areg_idx_t areg;
		preg_idx_t new_preg;
		preg_idx_t old_preg;
	} rob_model_t;

	logic      clk;
	logic      reset_i;
	logic      dispatch_valid_i;
	areg_idx_t dest_areg_i;
	areg_idx_t src_a_areg_i;
	areg_idx_t src_b_areg_i;
	logic      dispatch_ready_o;
	preg_idx_t dest_preg_o;
	preg_idx_t src_a_preg_o;
	logic      src_a_rdy_o;
	preg_idx_t src_b_preg_o;
	logic      src_b_rdy_o;
	rob_idx_t  rob_idx_o;
	logic      complete_valid_i;
	rob_idx_t  complete_idx_i;
	logic      retire_valid_o;
	areg_idx_t retire_areg_o;
	preg_idx_t retire_preg_o;
	areg_idx_t arch_areg_i;
	preg_idx_t arch_preg_o;

	//==========================================================================
	// reference model state
	//==========================================================================
	preg_idx_t  map_m [`CORE_AREG_NUM];		// speculative map
	preg_idx_t  commit_m [`CORE_AREG_NUM];	// committed map
	logic       rdy_m [`CORE_PREG_NUM];
	logic       done_m [`CORE_ROB_DEPTH];		// per ROB slot
	preg_idx_t  free_q [$];
	rob_model_t rob_q [$];					// program order, head first
	int         fill_left;				// pregs still to come from the fill
	preg_idx_t  next_fill;
	rob_idx_t   tail_m;
	logic       dut_fire;				// handshake on the DUT port this cycle
	integer     seed;
	int         phase;
	int         fresh_cnt;				// renamed dests in the first test
	int         dispatched_cnt;			// accepted at the DUT port
	int         retired_cnt;			// retirements seen at the DUT port

	// expected outputs for the current cycle
	logic       exp_ready;
	preg_idx_t  exp_dest_preg;
	preg_idx_t  exp_src_a_preg;
	logic       exp_src_a_rdy;
	preg_idx_t  exp_src_b_preg;
	logic       exp_src_b_rdy;
	rob_idx_t   exp_rob_idx;
	logic       exp_retire_valid;
	areg_idx_t  exp_retire_areg;
	preg_idx_t  exp_retire_preg;
	preg_idx_t  exp_arch_preg;

	rename_core u_dut (.*);

	always #4 clk = ~clk;

	task automatic abort_run();
		$display("test failed");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] want);
		$display("mismatch %s: dut %0h, expected %0h", name, got, want);
		abort_run();
	endtask

	function automatic int rand_below(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	// small areg set so sources hit recent dests often
	function automatic areg_idx_t pick_areg();
		if (rand_below(9) == 0) return ZERO_AREG;
		return areg_idx_t'(rand_below(8));
	endfunction

	task automatic init_model();
		for (int i = 0; i < `CORE_AREG_NUM; i++) begin
			map_m[i]    = preg_idx_t'(i);	// identity after reset
			commit_m[i] = preg_idx_t'(i);
		end
		for (int i = 0; i < `CORE_PREG_NUM; i++) rdy_m[i] = 1'b1;
		for (int i = 0; i < `CORE_ROB_DEPTH; i++) done_m[i] = 1'b0;
		free_q.delete();
		rob_q.delete();
		fill_left      = `CORE_PREG_NUM - `CORE_AREG_NUM;
		next_fill      = preg_idx_t'(`CORE_AREG_NUM);
		tail_m         = '0;
		dut_fire       = 1'b0;
		phase          = 0;
		fresh_cnt      = 0;
		dispatched_cnt = 0;
		retired_cnt    = 0;
	endtask

	// expectations from model state and the inputs of this cycle
	task automatic compute_expect();
		logic dest_zero;
		logic free_empty;
		dest_zero  = (dest_areg_i == ZERO_AREG);
		free_empty = (fill_left != 0) || (free_q.size() == 0);	// no allocation during fill
		exp_ready  = (!free_empty || dest_zero) && (rob_q.size() < `CORE_ROB_DEPTH);
		if (dest_zero) exp_dest_preg = map_m[ZERO_AREG];
		else if (free_q.size() != 0) exp_dest_preg = free_q[0];
		else exp_dest_preg = '0;
		exp_src_a_preg   = map_m[src_a_areg_i];
		exp_src_a_rdy    = rdy_m[exp_src_a_preg];
		exp_src_b_preg   = map_m[src_b_areg_i];
		exp_src_b_rdy    = rdy_m[exp_src_b_preg];
		exp_rob_idx      = tail_m;
		exp_retire_valid = (rob_q.size() != 0) && done_m[rob_q[0].idx];
		if (rob_q.size() != 0) begin
			exp_retire_areg = rob_q[0].areg;
			exp_retire_preg = rob_q[0].new_preg;
		end
		exp_arch_preg = commit_m[arch_areg_i];
	endtask

	// what the edge does in order of retire, completion, dispatch and fill
	task automatic apply_model();
		rob_model_t ent;
		logic       fire;
		fire = dispatch_valid_i && exp_ready;
		if (exp_retire_valid) begin
			ent = rob_q.pop_front();
			if (ent.has_dest) begin
				commit_m[ent.areg] = ent.new_preg;
				free_q.push_back(ent.old_preg);	// old tag recycled
			end
		end
		if (complete_valid_i) begin
			done_m[complete_idx_i] = 1'b1;
			foreach (rob_q[i]) begin
				if (rob_q[i].idx == complete_idx_i && rob_q[i].has_dest) begin
					rdy_m[rob_q[i].new_preg] = 1'b1;
				end
			end
		end
		if (fire) begin
			ent.idx      = tail_m;
			ent.has_dest = (dest_areg_i != ZERO_AREG);
			ent.areg     = dest_areg_i;
			ent.new_preg = exp_dest_preg;
			ent.old_preg = map_m[dest_areg_i];
			rob_q.push_back(ent);
			done_m[tail_m] = 1'b0;
			tail_m = (tail_m == rob_idx_t'(`CORE_ROB_DEPTH - 1)) ? '0 : tail_m + 1'b1;
			if (ent.has_dest) begin
				void'(free_q.pop_front());
				map_m[dest_areg_i]   = exp_dest_preg;
				rdy_m[exp_dest_preg] = 1'b0;	// pending until completion
				if (phase == 1) fresh_cnt++;
			end
		end
		if (fill_left != 0) begin
			free_q.push_back(next_fill);		// one upper preg per cycle
			next_fill = next_fill + 1'b1;
			fill_left--;
		end
	endtask

	// inputs are already set 1 ns after the edge
	task automatic cycle();
		compute_expect();
		@(posedge clk);
		apply_model();
		#1;
	endtask

	task automatic pick_operands();
		dest_areg_i  = pick_areg();
		src_a_areg_i = pick_areg();
		src_b_areg_i = pick_areg();
	endtask

	// random slot among entries not yet completed
	task automatic pick_pending(output logic found, output rob_idx_t idx);
		int n;
		int k;
		n   = 0;
		idx = '0;
		foreach (rob_q[i]) if (!done_m[rob_q[i].idx]) n++;
		found = (n != 0);
		if (n != 0) begin
			k = rand_below(n);
			foreach (rob_q[i]) begin
				if (!done_m[rob_q[i].idx]) begin
					if (k == 0) idx = rob_q[i].idx;
					k--;
				end
			end
		end
	endtask

	//==========================================================================
	// stimulus
	//==========================================================================
	task automatic dispatch_one(input areg_idx_t dest, input areg_idx_t src_a,
			input areg_idx_t src_b);
		dispatch_valid_i = 1'b1;
		dest_areg_i      = dest;
		src_a_areg_i     = src_a;
		src_b_areg_i     = src_b;
		do begin
			cycle();
		end while (!dut_fire);		// held until accepted
	endtask

	task automatic random_traffic(input int cycles);
		logic     found;
		rob_idx_t idx;
		repeat (cycles) begin
			dispatch_valid_i = (rand_below(4) != 0);
			pick_operands();
			pick_pending(found, idx);
			complete_valid_i = found && (rand_below(2) == 0);	// random completion order
			complete_idx_i   = idx;
			arch_areg_i      = pick_areg();
			cycle();
		end
	endtask

	task automatic drain_rob();
		logic     found;
		rob_idx_t idx;
		dispatch_valid_i = 1'b0;
		while (rob_q.size() != 0) begin
			pick_pending(found, idx);
			complete_valid_i = found;
			complete_idx_i   = idx;
			arch_areg_i      = pick_areg();
			cycle();
		end
		complete_valid_i = 1'b0;
	endtask

	// fill the ROB with no completion, hold against it, then free one slot
	task automatic burst_until_full();
		int accepted;
		accepted         = 0;
		complete_valid_i = 1'b0;
		dispatch_valid_i = 1'b1;
		do begin
			pick_operands();
			cycle();
			if (dut_fire) accepted++;
		end while (dut_fire);
		assert (accepted == `CORE_ROB_DEPTH)
			else report_mismatch("accepted count", 32'(accepted), 32'(`CORE_ROB_DEPTH));
		repeat (STALL_HOLD) begin
			cycle();
			assert (!dut_fire) else begin
				$display("an instruction was taken while the ROB was full");
				abort_run();
			end
		end
		complete_valid_i = 1'b1;
		complete_idx_i   = rob_q[0].idx;	// head entry retires next
		cycle();
		complete_valid_i = 1'b0;
		do begin
			cycle();
		end while (!dut_fire);		// stalled instruction goes after the retire
		dispatch_valid_i = 1'b0;
	endtask

	initial begin
		seed             = 32'hf72b8c33;
		clk              = 1'b0;
		reset_i          = 1'b1;
		dispatch_valid_i = 1'b0;
		dest_areg_i      = '0;
		src_a_areg_i     = '0;
		src_b_areg_i     = '0;
		complete_valid_i = 1'b0;
		complete_idx_i   = '0;
		arch_areg_i      = '0;
		init_model();
		compute_expect();
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		reset_i = 1'b0;

		// fresh pregs in order once the fill is done and none for the zero dest
		phase = 1;
		dispatch_one(areg_idx_t'(5), areg_idx_t'(0), areg_idx_t'(1));
		dispatch_one(ZERO_AREG, areg_idx_t'(5), areg_idx_t'(2));
		dispatch_one(areg_idx_t'(6), areg_idx_t'(5), ZERO_AREG);
		dispatch_one(areg_idx_t'(7), areg_idx_t'(6), areg_idx_t'(6));
		dispatch_one(areg_idx_t'(5), areg_idx_t'(7), areg_idx_t'(5));
		phase = 0;
		dispatch_valid_i = 1'b0;

		// long enough to use up the first 32 pregs and recycle
		random_traffic(RAND_CYCLES);
		drain_rob();

		burst_until_full();
		drain_rob();
		cycle();

		if (dispatched_cnt == retired_cnt) begin
			$display("test passed");
			$finish;
		end else begin
			$display("dispatched %0d instructions but retired %0d", dispatched_cnt, retired_cnt);
			abort_run();
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("run did not finish within %0d cycles", WATCHDOG_CYCLES);
		abort_run();
	end

	// handshakes seen on the DUT ports
	always @(negedge clk) begin
		if (!reset_i) begin
			dut_fire = dispatch_valid_i && dispatch_ready_o;
			if (dut_fire) dispatched_cnt++;
			if (retire_valid_o) retired_cnt++;
		end
	end

	//==========================================================================
	// checks sampled at the falling edge where everything is settled
	//==========================================================================
	ready_chk: assert property (@(negedge clk) disable iff (reset_i)
		dispatch_ready_o == exp_ready)
		else report_mismatch("dispatch_ready_o", 32'(dispatch_ready_o), 32'(exp_ready));

	dest_chk: assert property (@(negedge clk) disable iff (reset_i)
		(dispatch_valid_i && exp_ready) |-> dest_preg_o == exp_dest_preg)
		else report_mismatch("dest_preg_o", 32'(dest_preg_o), 32'(exp_dest_preg));

	// first test takes its tags straight from the fill order
	fresh_chk: assert property (@(negedge clk) disable iff (reset_i)
		(phase == 1 && dispatch_valid_i && exp_ready && dest_areg_i != ZERO_AREG)
		|-> dest_preg_o == preg_idx_t'(`CORE_AREG_NUM + fresh_cnt))
		else report_mismatch("dest_preg_o", 32'(dest_preg_o), 32'(`CORE_AREG_NUM + fresh_cnt));

	src_a_chk: assert property (@(negedge clk) disable iff (reset_i)
		src_a_preg_o == exp_src_a_preg)
		else report_mismatch("src_a_preg_o", 32'(src_a_preg_o), 32'(exp_src_a_preg));

	src_a_rdy_chk: assert property (@(negedge clk) disable iff (reset_i)
		src_a_rdy_o == exp_src_a_rdy)
		else report_mismatch("src_a_rdy_o", 32'(src_a_rdy_o), 32'(exp_src_a_rdy));

	src_b_chk: assert property (@(negedge clk) disable iff (reset_i)
		src_b_preg_o == exp_src_b_preg)
		else report_mismatch("src_b_preg_o", 32'(src_b_preg_o), 32'(exp_src_b_preg));

	src_b_rdy_chk: assert property (@(negedge clk) disable iff (reset_i)
		src_b_rdy_o == exp_src_b_rdy)
		else report_mismatch("src_b_rdy_o", 32'(src_b_rdy_o), 32'(exp_src_b_rdy));

	rob_idx_chk: assert property (@(negedge clk) disable iff (reset_i)
		rob_idx_o == exp_rob_idx)
		else report_mismatch("rob_idx_o", 32'(rob_idx_o), 32'(exp_rob_idx));

	retire_chk: assert property (@(negedge clk) disable iff (reset_i)
		retire_valid_o == exp_retire_valid)
		else report_mismatch("retire_valid_o", 32'(retire_valid_o), 32'(exp_retire_valid));

	retire_areg_chk: assert property (@(negedge clk) disable iff (reset_i)
		exp_retire_valid |-> retire_areg_o == exp_retire_areg)
		else report_mismatch("retire_areg_o", 32'(retire_areg_o), 32'(exp_retire_areg));

	retire_preg_chk: assert property (@(negedge clk) disable iff (reset_i)
		exp_retire_valid |-> retire_preg_o == exp_retire_preg)
		else report_mismatch("retire_preg_o", 32'(retire_preg_o), 32'(exp_retire_preg));

	arch_chk: assert property (@(negedge clk) disable iff (reset_i)
		arch_preg_o == exp_arch_preg)
		else report_mismatch("arch_preg_o", 32'(arch_preg_o), 32'(exp_arch_preg));

endmodule
